//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_p4_ingress_merge
FILELIST  := build.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/tb_p4_ingress_merge.sv
////////////////////////////////////////
// Directed testbench for the four-port ingress merge,
// per-port expected queues checked by a bus monitor
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_p4_ingress_merge;

    import ing_bus_pkg::*;

    localparam int RESET_CYCLES = 8;
    // Test 2, test 3 (two packets per port), test 4 worst case, test 5
    localparam int TOTAL_WORDS  = 5 + 50 + 20 * 64 + 1;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + TOTAL_WORDS * NUM_PORTS * 4;

    // Expected word record is {last, keep, data}
    typedef logic [1+DATA_BYTES+DATA_BYTES*8-1:0] word_rec_t;

    logic                 ing_bus;
    logic                 rst_n;
    logic [NUM_PORTS-1:0] port_valid;
    bus_data_t            port_data [NUM_PORTS];
    bus_keep_t            port_keep [NUM_PORTS];
    logic [NUM_PORTS-1:0] port_last;
    logic [NUM_PORTS-1:0] port_ready;
    logic                 out_valid;
    bus_data_t            out_data;
    bus_keep_t            out_keep;
    logic                 out_last;
    port_idx_t            out_user;

    int        seed;
    int        errors = 0;
    int        room_waits = 0;
    word_rec_t exp_q [NUM_PORTS][$];
    logic      in_pkt = 1'b0;
    port_idx_t cur_user = '0;

    p4_ingress_merge UUT (
        .ing_bus    (ing_bus),
        .rst_n      (rst_n),
        .port_valid (port_valid),
        .port_data  (port_data),
        .port_keep  (port_keep),
        .port_last  (port_last),
        .port_ready (port_ready),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_keep   (out_keep),
        .out_last   (out_last),
        .out_user   (out_user)
    );

    initial begin
        ing_bus = 1'b0;
        forever #20 ing_bus = ~ing_bus;
    end

    ////////////////////////////////////////
    // Helpers

    task automatic check_value(input string what, input word_rec_t got, input word_rec_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Contiguous keep with n valid bytes from byte 0
    function automatic bus_keep_t keep_for(input int n);
        return bus_keep_t'((16'd1 << n) - 16'd1);
    endfunction

    function automatic int pending_words();
        int total;
        total = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            total += exp_q[p].size();
        end
        return total;
    endfunction

    // Called and returns 2 ns after a rising edge
    task automatic send_packet(input int port, input int len, input bus_keep_t keep);
        bus_data_t word;
        logic      last;
        int        waits;
        for (int i = 0; i < len; i++) begin
            word = {$random(seed), $random(seed)};
            last = (i == len - 1);
            port_valid[port] = 1'b1;
            port_data[port]  = word;
            port_keep[port]  = last ? keep : '1;
            port_last[port]  = last;
            // Transfer happens on the edge after a mid-cycle ready
            waits = 1;
            @(negedge ing_bus);
            while (!port_ready[port]) begin
                @(negedge ing_bus);
                waits++;
            end
            // Slot comes round within NUM_PORTS cycles unless the region is full
            if (waits > NUM_PORTS) begin
                room_waits++;
            end
            exp_q[port].push_back({last, port_keep[port], word});
            @(posedge ing_bus);
            #2;
        end
        port_valid[port] = 1'b0;
        port_last[port]  = 1'b0;
        port_keep[port]  = '1;
    endtask

    task automatic send_pair(input int port);
        send_packet(port, 3 + port, keep_for(port + 1));
        send_packet(port, 8, keep_for(8 - port));
    endtask

    task automatic wait_drain();
        while (pending_words() != 0) begin
            @(negedge ing_bus);
        end
        repeat (4) @(posedge ing_bus);
        #2;
    endtask

    ////////////////////////////////////////
    // Output monitor

    always @(negedge ing_bus) begin
        if (rst_n) begin
            check_value("more than one port_ready", word_rec_t'($countones(port_ready) > 1), '0);
            if (in_pkt) begin
                check_value("gap inside packet", word_rec_t'(out_valid), word_rec_t'(1));
                check_value("out_user changed in packet", word_rec_t'(out_user),
                            word_rec_t'(cur_user));
            end
            if (out_valid) begin
                if (exp_q[out_user].size() == 0) begin
                    errors++;
                    $display("Unexpected output word for port %0d at time %0t", out_user, $time);
                end else begin
                    check_value("output word", {out_last, out_keep, out_data},
                                exp_q[out_user].pop_front());
                end
            end
            in_pkt   = out_valid && !out_last;
            cur_user = out_user;
        end
    end

    ////////////////////////////////////////
    // Tests

    task automatic test_reset();
        repeat (RESET_CYCLES) begin
            @(negedge ing_bus);
            check_value("port_ready in reset", word_rec_t'(port_ready), '0);
            check_value("out_valid in reset", word_rec_t'(out_valid), '0);
            check_value("out_last in reset", word_rec_t'(out_last), '0);
        end
        @(posedge ing_bus);
        #2;
        rst_n = 1'b1;
        for (int i = 0; i < 2; i++) begin
            @(negedge ing_bus);
            if (i == 0) begin
                check_value("port_ready after reset", word_rec_t'(port_ready), '0);
            end
            check_value("out_valid after reset", word_rec_t'(out_valid), '0);
            check_value("out_last after reset", word_rec_t'(out_last), '0);
        end
        @(posedge ing_bus);
        #2;
    endtask

    task automatic test_single_packet();
        send_packet(2, 5, keep_for(5));
        wait_drain();
    endtask

    task automatic test_all_ports();
        fork
            send_pair(0);
            send_pair(1);
            send_pair(2);
            send_pair(3);
        join
        wait_drain();
    endtask

    task automatic test_random_burst();
        int len;
        int nbytes;
        room_waits = 0;
        for (int n = 0; n < 20; n++) begin
            len    = 1 + int'($unsigned($random(seed)) % 64);
            nbytes = 1 + int'($unsigned($random(seed)) % 8);
            // First packet fills the whole region, so the next one waits for room
            if (n == 0) begin
                len = 64;
            end
            send_packet(3, len, keep_for(nbytes));
        end
        wait_drain();
        check_value("port_ready low for room", word_rec_t'(room_waits > 0), word_rec_t'(1));
    endtask

    task automatic test_one_word();
        send_packet(1, 1, keep_for(3));
        wait_drain();
    endtask

    initial begin
        seed  = 32'h9616;
        rst_n = 1'b0;
        port_valid = '0;
        port_last  = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            port_data[p] = '0;
            port_keep[p] = '1;
        end

        test_reset();
        test_single_packet();
        test_all_ports();
        test_random_burst();
        test_one_word();

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Bound scales with the words sent, four slots per word per port
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge ing_bus);
        $display("Watchdog expired after %0d cycles, the output never drained", WATCHDOG_CYCLES);
        $display("Errors: %0d", errors);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
rtl/ing_bus_pkg.sv
rtl/ing_buf_pkg.sv
rtl/ing_port_writer.sv
rtl/ing_pkt_buffer.sv
rtl/ing_bus_reader.sv
rtl/p4_ingress_merge.sv
bench/tb_p4_ingress_merge.sv

//--- rtl/ing_buf_pkg.sv
////////////////////////////////////////
// Packet buffer geometry, pointer and attribute
// types for the writer, buffer and reader
////////////////////////////////////////

`default_nettype none

package ing_buf_pkg;

    // Region size is also the largest packet allowed
    localparam int PORT_BUF_WORDS = 64;
    localparam int PORT_PKT_SLOTS = 16;

    typedef logic [$clog2(PORT_BUF_WORDS)-1:0] word_ptr_t;
    typedef logic [$clog2(PORT_BUF_WORDS):0]   word_cnt_t;
    typedef logic [$clog2(PORT_PKT_SLOTS)-1:0] pkt_ptr_t;
    typedef logic [$clog2(PORT_PKT_SLOTS):0]   pkt_cnt_t;

    // Attribute entry is {last word pointer, keep}, keep in the low bits
    localparam int ATR_PTR_LSB = ing_bus_pkg::DATA_BYTES;
    typedef logic [ATR_PTR_LSB+$bits(word_ptr_t)-1:0] atr_t;

    // RAM addresses are {port, pointer}
    typedef logic [$bits(ing_bus_pkg::port_idx_t)+$bits(word_ptr_t)-1:0] buf_addr_t;
    typedef logic [$bits(ing_bus_pkg::port_idx_t)+$bits(pkt_ptr_t)-1:0]  atr_addr_t;

    // Reader FSM
    typedef enum logic [1:0] {
        SCAN,
        ATR_FETCH,
        STREAM
    } rd_state_t;

endpackage

`default_nettype wire

//--- rtl/ing_bus_pkg.sv
////////////////////////////////////////
// Ingress bus geometry and word types, shared by
// the merge RTL and its testbench
////////////////////////////////////////

`default_nettype none

package ing_bus_pkg;

    // Physical ports merged onto the bus
    localparam int NUM_PORTS  = 4;
    localparam int DATA_BYTES = 8;

    typedef logic [DATA_BYTES*8-1:0]      bus_data_t;
    // Valid bytes are contiguous from byte 0
    typedef logic [DATA_BYTES-1:0]        bus_keep_t;
    typedef logic [$clog2(NUM_PORTS)-1:0] port_idx_t;

endpackage

`default_nettype wire

//--- rtl/ing_bus_reader.sv
////////////////////////////////////////
// Round-robin packet reader, streams whole packets
// from the buffer onto the ingress bus
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ing_bus_reader (
    input  var logic                                ing_bus,
    input  var logic                                rst_n,
    input  var logic [ing_bus_pkg::NUM_PORTS-1:0]   pkt_avail,
    input  var ing_bus_pkg::bus_data_t              rd_data,
    input  var ing_buf_pkg::atr_t                   atr_rd_data,
    output logic                                    rd_en,
    output ing_buf_pkg::buf_addr_t                  rd_addr,
    output logic                                    atr_rd_en,
    output ing_buf_pkg::atr_addr_t                  atr_rd_addr,
    output logic                                    word_release,
    output logic                                    pkt_release,
    output ing_bus_pkg::port_idx_t                  release_port,
    output logic                                    out_valid,
    output ing_bus_pkg::bus_data_t                  out_data,
    output ing_bus_pkg::bus_keep_t                  out_keep,
    output logic                                    out_last,
    output ing_bus_pkg::port_idx_t                  out_user
);

    import ing_bus_pkg::*;
    import ing_buf_pkg::*;

    rd_state_t state;
    port_idx_t sel;
    port_idx_t next_sel;
    word_ptr_t rd_ptr  [NUM_PORTS];
    pkt_ptr_t  atr_ptr [NUM_PORTS];

    // Attribute of the packet in flight
    word_ptr_t last_ptr;
    bus_keep_t last_keep;
    logic      is_last;

    // Stage aligned with rd_data
    logic      pend_valid;
    logic      pend_last;
    bus_keep_t pend_keep;
    port_idx_t pend_port;

    assign next_sel = (sel == port_idx_t'(NUM_PORTS - 1)) ? '0 : sel + 1'b1;
    assign is_last  = rd_ptr[sel] == last_ptr;

    always_comb begin
        atr_rd_en   = (state == SCAN) && pkt_avail[sel];
        atr_rd_addr = {sel, atr_ptr[sel]};
        rd_en       = state == STREAM;
        rd_addr     = {sel, rd_ptr[sel]};
    end

    ////////////////////////////////////////
    // FSM and pointers

    always_ff @(posedge ing_bus or negedge rst_n) begin
        if (!rst_n) begin
            state <= SCAN;
            sel   <= '0;
            for (int p = 0; p < NUM_PORTS; p++) begin
                rd_ptr[p]  <= '0;
                atr_ptr[p] <= '0;
            end
        end else begin
            case (state)
                SCAN: begin
                    if (pkt_avail[sel]) begin
                        state <= ATR_FETCH;
                    end else begin
                        sel <= next_sel;
                    end
                end
                ATR_FETCH: begin
                    atr_ptr[sel] <= atr_ptr[sel] + 1'b1;
                    state        <= STREAM;
                end
                STREAM: begin
                    rd_ptr[sel] <= rd_ptr[sel] + 1'b1;
                    // Hand the bus to the next port after a full packet
                    if (is_last) begin
                        state <= SCAN;
                        sel   <= next_sel;
                    end
                end
                default: state <= SCAN;
            endcase
        end
    end

    // Attribute returns during ATR_FETCH
    always_ff @(posedge ing_bus) begin
        if (state == ATR_FETCH) begin
            last_ptr  <= atr_rd_data[ATR_PTR_LSB +: $bits(word_ptr_t)];
            last_keep <= atr_rd_data[ATR_PTR_LSB-1:0];
        end
    end

    ////////////////////////////////////////
    // Output pipeline

    always_ff @(posedge ing_bus or negedge rst_n) begin
        if (!rst_n) begin
            pend_valid <= 1'b0;
            pend_last  <= 1'b0;
            out_valid  <= 1'b0;
            out_last   <= 1'b0;
        end else begin
            pend_valid <= rd_en;
            pend_last  <= rd_en && is_last;
            out_valid  <= pend_valid;
            out_last   <= pend_last;
        end
    end

    always_ff @(posedge ing_bus) begin
        pend_keep <= (rd_en && is_last) ? last_keep : '1;
        pend_port <= sel;
        out_data  <= rd_data;
        out_keep  <= pend_keep;
        out_user  <= pend_port;
    end

    // Space is freed once the word has left the RAM
    assign word_release = out_valid;
    assign pkt_release  = out_valid && out_last;
    assign release_port = out_user;

endmodule

`default_nettype wire

//--- rtl/ing_pkt_buffer.sv
////////////////////////////////////////
// Shared data and attribute RAMs with per-port
// word and packet occupancy
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ing_pkt_buffer (
    input  var logic                                ing_bus,
    input  var logic                                rst_n,
    input  var logic                                wr_en,
    input  var ing_buf_pkg::buf_addr_t              wr_addr,
    input  var ing_bus_pkg::bus_data_t              wr_data,
    input  var logic                                atr_wr_en,
    input  var ing_buf_pkg::atr_addr_t              atr_wr_addr,
    input  var ing_buf_pkg::atr_t                   atr_wr_data,
    input  var logic                                rd_en,
    input  var ing_buf_pkg::buf_addr_t              rd_addr,
    input  var logic                                atr_rd_en,
    input  var ing_buf_pkg::atr_addr_t              atr_rd_addr,
    input  var logic                                word_release,
    input  var logic                                pkt_release,
    input  var ing_bus_pkg::port_idx_t              release_port,
    output ing_bus_pkg::bus_data_t                  rd_data,
    output ing_buf_pkg::atr_t                       atr_rd_data,
    output logic [ing_bus_pkg::NUM_PORTS-1:0]       port_room,
    output logic [ing_bus_pkg::NUM_PORTS-1:0]       pkt_avail
);

    import ing_bus_pkg::*;
    import ing_buf_pkg::*;

    bus_data_t data_ram [NUM_PORTS*PORT_BUF_WORDS];
    atr_t      atr_ram  [NUM_PORTS*PORT_PKT_SLOTS];

    word_cnt_t word_cnt [NUM_PORTS];
    pkt_cnt_t  pkt_cnt  [NUM_PORTS];

    port_idx_t             wr_port;
    port_idx_t             atr_port;
    logic [NUM_PORTS-1:0]  word_inc;
    logic [NUM_PORTS-1:0]  word_dec;
    logic [NUM_PORTS-1:0]  pkt_inc;
    logic [NUM_PORTS-1:0]  pkt_dec;

    // Port index sits in the top bits of each address
    assign wr_port  = wr_addr[$bits(buf_addr_t)-1 -: $bits(port_idx_t)];
    assign atr_port = atr_wr_addr[$bits(atr_addr_t)-1 -: $bits(port_idx_t)];

    ////////////////////////////////////////
    // RAMs, registered read

    always_ff @(posedge ing_bus) begin
        if (wr_en) begin
            data_ram[wr_addr] <= wr_data;
        end
        if (atr_wr_en) begin
            atr_ram[atr_wr_addr] <= atr_wr_data;
        end
        if (rd_en) begin
            rd_data <= data_ram[rd_addr];
        end
        if (atr_rd_en) begin
            atr_rd_data <= atr_ram[atr_rd_addr];
        end
    end

    ////////////////////////////////////////
    // Occupancy

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            word_inc[p]  = wr_en && (wr_port == port_idx_t'(p));
            word_dec[p]  = word_release && (release_port == port_idx_t'(p));
            pkt_inc[p]   = atr_wr_en && (atr_port == port_idx_t'(p));
            pkt_dec[p]   = pkt_release && (release_port == port_idx_t'(p));
            // Room means one more word and one more attribute slot
            port_room[p] = (word_cnt[p] < word_cnt_t'(PORT_BUF_WORDS)) &&
                           (pkt_cnt[p] < pkt_cnt_t'(PORT_PKT_SLOTS));
            pkt_avail[p] = pkt_cnt[p] != '0;
        end
    end

    always_ff @(posedge ing_bus or negedge rst_n) begin
        if (!rst_n) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                word_cnt[p] <= '0;
                pkt_cnt[p]  <= '0;
            end
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                word_cnt[p] <= word_cnt[p] + word_cnt_t'(word_inc[p])
                                           - word_cnt_t'(word_dec[p]);
                pkt_cnt[p]  <= pkt_cnt[p] + pkt_cnt_t'(pkt_inc[p])
                                          - pkt_cnt_t'(pkt_dec[p]);
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/ing_port_writer.sv
////////////////////////////////////////
// Round-robin port scheduler, stores accepted words
// and last-word attributes into the packet buffer
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ing_port_writer (
    input  var logic                                ing_bus,
    input  var logic                                rst_n,
    input  var logic [ing_bus_pkg::NUM_PORTS-1:0]   port_valid,
    input  var ing_bus_pkg::bus_data_t              port_data [ing_bus_pkg::NUM_PORTS],
    input  var ing_bus_pkg::bus_keep_t              port_keep [ing_bus_pkg::NUM_PORTS],
    input  var logic [ing_bus_pkg::NUM_PORTS-1:0]   port_last,
    input  var logic [ing_bus_pkg::NUM_PORTS-1:0]   port_room,
    output logic [ing_bus_pkg::NUM_PORTS-1:0]       port_ready,
    output logic                                    wr_en,
    output ing_buf_pkg::buf_addr_t                  wr_addr,
    output ing_bus_pkg::bus_data_t                  wr_data,
    output logic                                    atr_wr_en,
    output ing_buf_pkg::atr_addr_t                  atr_wr_addr,
    output ing_buf_pkg::atr_t                       atr_wr_data
);

    import ing_bus_pkg::*;
    import ing_buf_pkg::*;

    port_idx_t slot;
    word_ptr_t wr_ptr  [NUM_PORTS];
    pkt_ptr_t  atr_ptr [NUM_PORTS];
    logic      run;
    logic      accept;

    ////////////////////////////////////////
    // Slot decode

    always_comb begin
        // Only the slot owner sees ready, and only with room in its region
        port_ready       = '0;
        port_ready[slot] = run && port_room[slot];
        accept           = run && port_valid[slot] && port_room[slot];

        wr_en       = accept;
        wr_addr     = {slot, wr_ptr[slot]};
        wr_data     = port_data[slot];

        atr_wr_en   = accept && port_last[slot];
        atr_wr_addr = {slot, atr_ptr[slot]};
        atr_wr_data = {wr_ptr[slot], port_keep[slot]};
    end

    ////////////////////////////////////////
    // Slot and pointer update

    always_ff @(posedge ing_bus or negedge rst_n) begin
        if (!rst_n) begin
            run  <= 1'b0;
            slot <= '0;
            for (int p = 0; p < NUM_PORTS; p++) begin
                wr_ptr[p]  <= '0;
                atr_ptr[p] <= '0;
            end
        end else begin
            // Ready stays low until the first edge after reset
            run <= 1'b1;

            // Advance every cycle, whether or not the port had a word
            if (slot == port_idx_t'(NUM_PORTS - 1)) begin
                slot <= '0;
            end else begin
                slot <= slot + 1'b1;
            end

            if (accept) begin
                wr_ptr[slot] <= wr_ptr[slot] + 1'b1;
                if (port_last[slot]) begin
                    atr_ptr[slot] <= atr_ptr[slot] + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/p4_ingress_merge.sv
////////////////////////////////////////
// Ingress merge top, four ports into one bus
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module p4_ingress_merge (
    input  var logic                                ing_bus,
    input  var logic                                rst_n,
    input  var logic [ing_bus_pkg::NUM_PORTS-1:0]   port_valid,
    input  var ing_bus_pkg::bus_data_t              port_data [ing_bus_pkg::NUM_PORTS],
    input  var ing_bus_pkg::bus_keep_t              port_keep [ing_bus_pkg::NUM_PORTS],
    input  var logic [ing_bus_pkg::NUM_PORTS-1:0]   port_last,
    output logic [ing_bus_pkg::NUM_PORTS-1:0]       port_ready,
    output logic                                    out_valid,
    output ing_bus_pkg::bus_data_t                  out_data,
    output ing_bus_pkg::bus_keep_t                  out_keep,
    output logic                                    out_last,
    output ing_bus_pkg::port_idx_t                  out_user
);

    import ing_bus_pkg::*;
    import ing_buf_pkg::*;

    ////////////////////////////////////////
    // Writer to buffer

    logic      wr_en;
    buf_addr_t wr_addr;
    bus_data_t wr_data;
    logic      atr_wr_en;
    atr_addr_t atr_wr_addr;
    atr_t      atr_wr_data;

    logic [NUM_PORTS-1:0] port_room;

    ////////////////////////////////////////
    // Buffer and reader

    logic                 rd_en;
    buf_addr_t            rd_addr;
    bus_data_t            rd_data;
    logic                 atr_rd_en;
    atr_addr_t            atr_rd_addr;
    atr_t                 atr_rd_data;
    logic                 word_release;
    logic                 pkt_release;
    port_idx_t            release_port;
    logic [NUM_PORTS-1:0] pkt_avail;

    ing_port_writer u_writer (
        .ing_bus     (ing_bus),
        .rst_n       (rst_n),
        .port_valid  (port_valid),
        .port_data   (port_data),
        .port_keep   (port_keep),
        .port_last   (port_last),
        .port_room   (port_room),
        .port_ready  (port_ready),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .atr_wr_en   (atr_wr_en),
        .atr_wr_addr (atr_wr_addr),
        .atr_wr_data (atr_wr_data)
    );

    ing_pkt_buffer u_buffer (
        .ing_bus      (ing_bus),
        .rst_n        (rst_n),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .atr_wr_en    (atr_wr_en),
        .atr_wr_addr  (atr_wr_addr),
        .atr_wr_data  (atr_wr_data),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .atr_rd_en    (atr_rd_en),
        .atr_rd_addr  (atr_rd_addr),
        .word_release (word_release),
        .pkt_release  (pkt_release),
        .release_port (release_port),
        .rd_data      (rd_data),
        .atr_rd_data  (atr_rd_data),
        .port_room    (port_room),
        .pkt_avail    (pkt_avail)
    );

    ing_bus_reader u_reader (
        .ing_bus      (ing_bus),
        .rst_n        (rst_n),
        .pkt_avail    (pkt_avail),
        .rd_data      (rd_data),
        .atr_rd_data  (atr_rd_data),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .atr_rd_en    (atr_rd_en),
        .atr_rd_addr  (atr_rd_addr),
        .word_release (word_release),
        .pkt_release  (pkt_release),
        .release_port (release_port),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .out_keep     (out_keep),
        .out_last     (out_last),
        .out_user     (out_user)
    );

endmodule

`default_nettype wire
